//--- uart_pkg.sv
/* shared constants and types for the 8N1 serial port; the baud divisor is fixed
   at build time, so CLK_FREQ_HZ must be an integer multiple of BAUD_RATE */
package uart_pkg;

  localparam int CLK_FREQ_HZ  = 10_000_000;
  localparam int BAUD_RATE    = 1_000_000;
  localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;
  // mid-bit sampling offset
  localparam int HALF_BIT     = CLKS_PER_BIT / 2;
  localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);

  typedef logic [7:0]            uart_byte_t;
  typedef logic [11:0]           apb_addr_t;
  typedef logic [31:0]           apb_data_t;
  typedef logic [BAUD_CNT_W-1:0] baud_cnt_t;
  typedef logic [2:0]            bit_idx_t;

  // register map, byte addresses
  localparam apb_addr_t ADDR_TXDATA = 12'h000;
  localparam apb_addr_t ADDR_RXDATA = 12'h004;
  localparam apb_addr_t ADDR_STATUS = 12'h008;

  // status bit positions
  localparam int STAT_TX_BUSY    = 0;
  localparam int STAT_RX_VALID   = 1;
  localparam int STAT_RX_OVERRUN = 2;
  localparam int STAT_FRAME_ERR  = 3;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic       valid;
    uart_byte_t data;
  } tx_req_t;

  typedef struct packed {
    logic       valid;
    uart_byte_t data;
    logic       frame_err;
  } rx_byte_t;

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

//--- uart_tx.sv
/* 8N1 transmitter, one frame takes 10 * CLKS_PER_BIT cycles
   a request is taken only while tx_ready_o is high, nothing is queued */
`timescale 1ns/100ps

module uart_tx (
  input  logic              clk_i,
  input  logic              reset_i,
  input  uart_pkg::tx_req_t tx_req_i,
  output logic              tx_ready_o,
  output logic              tx_o
);
  import uart_pkg::*;

  tx_state_e  state_q;
  baud_cnt_t  baud_cnt_q;
  bit_idx_t   bit_idx_q;
  uart_byte_t shift_q;
  logic       bit_done;

  assign bit_done   = (baud_cnt_q == baud_cnt_t'(CLKS_PER_BIT - 1));
  assign tx_ready_o = (state_q == TX_IDLE);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= TX_IDLE;
      baud_cnt_q <= '0;
      bit_idx_q  <= '0;
      tx_o       <= 1'b1;
    end else begin
      case (state_q)
        TX_IDLE: begin
          baud_cnt_q <= '0;
          bit_idx_q  <= '0;
          if (tx_req_i.valid) begin
            // start bit goes out on the next cycle
            tx_o    <= 1'b0;
            state_q <= TX_START;
          end
        end
        TX_START: begin
          if (bit_done) begin
            baud_cnt_q <= '0;
            tx_o       <= shift_q[0];
            state_q    <= TX_DATA;
          end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
          end
        end
        TX_DATA: begin
          if (bit_done) begin
            baud_cnt_q <= '0;
            if (bit_idx_q == 3'd7) begin
              tx_o    <= 1'b1;
              state_q <= TX_STOP;
            end else begin
              bit_idx_q <= bit_idx_q + 1'b1;
              tx_o      <= shift_q[0];
            end
          end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
          end
        end
        TX_STOP: begin
          if (bit_done) begin
            baud_cnt_q <= '0;
            state_q    <= TX_IDLE;
          end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // lsb first, next bit always sits in shift_q[0]
  always_ff @(posedge clk_i) begin
    if (state_q == TX_IDLE && tx_req_i.valid) begin
      shift_q <= tx_req_i.data;
    end else if (bit_done && (state_q == TX_START || state_q == TX_DATA)) begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule

//--- uart_rx.sv
/* 8N1 receiver with mid-bit sampling, cannot be stalled
   a short low glitch on rx_i is dropped, a low stop bit only flags frame_err */
`timescale 1ns/100ps

module uart_rx (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               rx_i,
  output uart_pkg::rx_byte_t rx_byte_o
);
  import uart_pkg::*;

  logic [1:0] sync_q;
  logic       rx_prev_q;
  logic       rx_s;
  logic       fall;
  rx_state_e  state_q;
  baud_cnt_t  baud_cnt_q;
  bit_idx_t   bit_idx_q;
  uart_byte_t shift_q;
  logic       valid_q;
  logic       frame_err_q;
  logic       half_done;
  logic       bit_done;

  // two-flop synchronizer, idle line is high
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q    <= 2'b11;
      rx_prev_q <= 1'b1;
    end else begin
      sync_q    <= {sync_q[0], rx_i};
      rx_prev_q <= rx_s;
    end
  end

  assign rx_s      = sync_q[1];
  assign fall      = rx_prev_q & ~rx_s;
  assign half_done = (baud_cnt_q == baud_cnt_t'(HALF_BIT - 1));
  assign bit_done  = (baud_cnt_q == baud_cnt_t'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= RX_IDLE;
      baud_cnt_q  <= '0;
      bit_idx_q   <= '0;
      valid_q     <= 1'b0;
      frame_err_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          baud_cnt_q <= '0;
          bit_idx_q  <= '0;
          if (fall) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          if (half_done) begin
            baud_cnt_q <= '0;
            // still low at mid start bit, otherwise a glitch
            state_q    <= rx_s ? RX_IDLE : RX_DATA;
          end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_done) begin
            baud_cnt_q <= '0;
            if (bit_idx_q == 3'd7) begin
              state_q <= RX_STOP;
            end else begin
              bit_idx_q <= bit_idx_q + 1'b1;
            end
          end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_done) begin
            baud_cnt_q  <= '0;
            valid_q     <= 1'b1;
            frame_err_q <= ~rx_s;
            state_q     <= RX_IDLE;
          end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // lsb arrives first, shift in from the top
  always_ff @(posedge clk_i) begin
    if (state_q == RX_DATA && bit_done) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

  assign rx_byte_o.valid     = valid_q;
  assign rx_byte_o.data      = shift_q;
  assign rx_byte_o.frame_err = frame_err_q;

endmodule

//--- uart_apb_regs.sv
/* zero-wait-state APB slave, TXDATA 0x0 (wo), RXDATA 0x4 (ro), STATUS 0x8
   refused writes and reads answer with pslverr and leave all state unchanged */
`timescale 1ns/100ps

module uart_apb_regs (
  input  logic               clk_i,
  input  logic               reset_i,
  input  uart_pkg::apb_req_t apb_req_i,
  output uart_pkg::apb_rsp_t apb_rsp_o,
  input  logic               tx_ready_i,
  output uart_pkg::tx_req_t  tx_req_o,
  input  uart_pkg::rx_byte_t rx_byte_i
);
  import uart_pkg::*;

  logic       access;
  logic       sel_tx;
  logic       sel_rx;
  logic       sel_stat;
  logic       err;
  logic       rx_read;
  logic       stat_write;
  logic       set_overrun;
  logic       clr_overrun;
  logic       clr_frame_err;
  logic       rx_valid_q;
  logic       overrun_q;
  logic       frame_err_q;
  uart_byte_t rx_data_q;
  apb_data_t  status_val;
  apb_data_t  rdata;

  // access phase, pready is tied high
  assign access   = apb_req_i.psel & apb_req_i.penable;
  assign sel_tx   = (apb_req_i.paddr == ADDR_TXDATA);
  assign sel_rx   = (apb_req_i.paddr == ADDR_RXDATA);
  assign sel_stat = (apb_req_i.paddr == ADDR_STATUS);

  always_comb begin
    err = 1'b0;
    if (access) begin
      if (sel_tx) begin
        err = ~apb_req_i.pwrite | ~tx_ready_i;
      end else if (sel_rx) begin
        err = apb_req_i.pwrite | ~rx_valid_q;
      end else if (!sel_stat) begin
        err = 1'b1;
      end
    end
  end

  assign rx_read    = access & sel_rx & ~apb_req_i.pwrite & rx_valid_q;
  assign stat_write = access & sel_stat & apb_req_i.pwrite;

  // single-cycle pulse, only when the transmitter can take it
  assign tx_req_o.valid = access & sel_tx & apb_req_i.pwrite & tx_ready_i;
  assign tx_req_o.data  = apb_req_i.pwdata[7:0];

  // a byte read in the same cycle a new one lands is not an overrun
  assign set_overrun   = rx_byte_i.valid & rx_valid_q & ~rx_read;
  assign clr_overrun   = stat_write & apb_req_i.pwdata[STAT_RX_OVERRUN];
  assign clr_frame_err = stat_write & apb_req_i.pwdata[STAT_FRAME_ERR];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rx_valid_q  <= 1'b0;
      overrun_q   <= 1'b0;
      frame_err_q <= 1'b0;
    end else begin
      if (rx_byte_i.valid) begin
        rx_valid_q <= 1'b1;
      end else if (rx_read) begin
        rx_valid_q <= 1'b0;
      end
      // a new event wins over a clear in the same cycle
      overrun_q   <= (overrun_q & ~clr_overrun) | set_overrun;
      frame_err_q <= (frame_err_q & ~clr_frame_err) | (rx_byte_i.valid & rx_byte_i.frame_err);
    end
  end

  // newest byte always overwrites
  always_ff @(posedge clk_i) begin
    if (rx_byte_i.valid) begin
      rx_data_q <= rx_byte_i.data;
    end
  end

  always_comb begin
    status_val                  = '0;
    status_val[STAT_TX_BUSY]    = ~tx_ready_i;
    status_val[STAT_RX_VALID]   = rx_valid_q;
    status_val[STAT_RX_OVERRUN] = overrun_q;
    status_val[STAT_FRAME_ERR]  = frame_err_q;
  end

  // read data is zero outside a good read
  always_comb begin
    rdata = '0;
    if (access && !apb_req_i.pwrite && !err) begin
      if (sel_rx) begin
        rdata = apb_data_t'(rx_data_q);
      end else if (sel_stat) begin
        rdata = status_val;
      end
    end
  end

  assign apb_rsp_o.prdata  = rdata;
  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = err;

endmodule

//--- uart_top.sv
/* APB serial port, fixed 8N1 at BAUD_RATE from a CLK_FREQ_HZ clock
   no parity, flow control, FIFOs or interrupts */
`timescale 1ns/100ps

module uart_top (
  input  logic               clk_i,
  input  logic               reset_i,
  input  uart_pkg::apb_req_t apb_req_i,
  output uart_pkg::apb_rsp_t apb_rsp_o,
  input  logic               rx_i,
  output logic               tx_o
);
  import uart_pkg::*;

  tx_req_t  tx_req;
  logic     tx_ready;
  rx_byte_t rx_byte;

  // register block
  uart_apb_regs i_uart_apb_regs (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .apb_req_i  (apb_req_i),
    .apb_rsp_o  (apb_rsp_o),
    .tx_ready_i (tx_ready),
    .tx_req_o   (tx_req),
    .rx_byte_i  (rx_byte)
  );

  // serial engines
  uart_tx i_uart_tx (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .tx_req_i   (tx_req),
    .tx_ready_o (tx_ready),
    .tx_o       (tx_o)
  );

  uart_rx i_uart_rx (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .rx_i      (rx_i),
    .rx_byte_o (rx_byte)
  );

endmodule

//--- uart_checker.sv
/* protocol checks bound into uart_top, active only outside reset */
`timescale 1ns/100ps

module uart_checker (
  input logic               clk_i,
  input logic               reset_i,
  input uart_pkg::apb_req_t apb_req_i,
  input uart_pkg::apb_rsp_t apb_rsp_i,
  input logic               tx_ready_i,
  input uart_pkg::tx_req_t  tx_req_i,
  input logic               tx_o
);
  import uart_pkg::*;

  // access phase only inside a selected transfer
  penable_needs_psel: assert property (@(posedge clk_i) disable iff (reset_i)
    apb_req_i.penable |-> apb_req_i.psel)
    else $error("penable high without psel");

  // zero wait states
  pready_in_access: assert property (@(posedge clk_i) disable iff (reset_i)
    apb_req_i.penable |-> apb_rsp_i.pready)
    else $error("pready low during an access phase");

  // idle line is high
  idle_line_high: assert property (@(posedge clk_i) disable iff (reset_i)
    tx_ready_i |-> tx_o)
    else $error("tx_o low while the transmitter is idle");

  tx_req_only_when_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    tx_req_i.valid |-> tx_ready_i)
    else $error("transmit request while the transmitter is busy");

endmodule

//--- uart_tb.sv
/* directed tests for uart_top over APB and the serial lines
   stops at the first mismatch, every wait is bounded */
`timescale 1ns/100ps

module uart_tb;
  import uart_pkg::*;

  localparam int POLL_LIMIT  = 100;
  localparam int FALL_LIMIT  = 200;
  localparam int READY_LIMIT = 8;

  logic     clk;
  logic     reset;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  logic     rx_drv;
  logic     loop_en;
  logic     rx_line;
  logic     tx_line;
  integer   seed;

  // tx_o can be looped back to rx_i
  assign rx_line = loop_en ? tx_line : rx_drv;

  uart_top i_uart_top (
    .clk_i     (clk),
    .reset_i   (reset),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp),
    .rx_i      (rx_line),
    .tx_o      (tx_line)
  );

  bind uart_top uart_checker i_uart_checker (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .apb_req_i  (apb_req_i),
    .apb_rsp_i  (apb_rsp_o),
    .tx_ready_i (tx_ready),
    .tx_req_i   (tx_req),
    .tx_o       (tx_o)
  );

  always #50 clk = ~clk;

  task automatic stop_run();
    $display("TB FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  // setup then access, response sampled mid access cycle
  task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    @(negedge clk);
    while (apb_rsp.pready !== 1'b1) begin
      if (waited == READY_LIMIT) begin
        $display("timeout waiting for pready on an APB access");
        stop_run();
      end
      waited++;
      @(negedge clk);
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk);
    #1;
    apb_req = '0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata, output logic err);
    apb_data_t unused;
    apb_access(1'b1, addr, wdata, unused, err);
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata, output logic err);
    apb_access(1'b0, addr, '0, rdata, err);
  endtask

  task automatic wait_status(input int bit_pos, input logic value, input string what);
    apb_data_t st;
    logic      err;
    int        polls;
    polls = 0;
    apb_read(ADDR_STATUS, st, err);
    while (st[bit_pos] !== value) begin
      if (polls == POLL_LIMIT) begin
        $display("timeout waiting for %s", what);
        stop_run();
      end
      polls++;
      apb_read(ADDR_STATUS, st, err);
    end
    check_bit("pslverr", err, 1'b0);
  endtask

  task automatic drive_bit(input logic value);
    rx_drv = value;
    repeat (CLKS_PER_BIT) @(posedge clk);
    #1;
  endtask

  // start, data lsb first, stop, then one idle bit time
  task automatic send_serial_frame(input uart_byte_t data, input logic stop_bit);
    @(posedge clk);
    #1;
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(data[i]);
    end
    drive_bit(stop_bit);
    drive_bit(1'b1);
  endtask

  task automatic capture_tx_frame(output uart_byte_t data, output logic start_bit,
                                  output logic stop_bit);
    int waited;
    waited = 0;
    while (tx_line !== 1'b0) begin
      if (waited == FALL_LIMIT) begin
        $display("timeout waiting for a start bit on tx_o");
        stop_run();
      end
      waited++;
      @(posedge clk);
      #1;
    end
    repeat (HALF_BIT) @(posedge clk);
    #1;
    start_bit = tx_line;
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(posedge clk);
      #1;
      data[i] = tx_line;
    end
    repeat (CLKS_PER_BIT) @(posedge clk);
    #1;
    stop_bit = tx_line;
  endtask

  task automatic read_expect(input apb_addr_t addr, input apb_data_t exp, input string name);
    apb_data_t rd;
    logic      err;
    apb_read(addr, rd, err);
    check_bit("pslverr", err, 1'b0);
    check_data(name, rd, exp);
  endtask

  task automatic test_reset_state();
    check_bit("tx_o", tx_line, 1'b1);
    check_bit("pslverr", apb_rsp.pslverr, 1'b0);
    check_data("prdata", apb_rsp.prdata, '0);
    read_expect(ADDR_STATUS, 32'h0, "status");
  endtask

  task automatic test_transmit();
    uart_byte_t got;
    logic       sb;
    logic       pb;
    logic       err;
    apb_write(ADDR_TXDATA, 32'hA5, err);
    check_bit("pslverr", err, 1'b0);
    // start bit begins one cycle after the access
    check_bit("tx_o", tx_line, 1'b0);
    fork
      capture_tx_frame(got, sb, pb);
      read_expect(ADDR_STATUS, 32'h1, "status");
    join
    check_bit("start bit", sb, 1'b0);
    check_byte("tx data", got, 8'hA5);
    check_bit("stop bit", pb, 1'b1);
    wait_status(STAT_TX_BUSY, 1'b0, "tx busy to clear");
    read_expect(ADDR_STATUS, 32'h0, "status");
  endtask

  task automatic test_receive();
    send_serial_frame(8'h3C, 1'b1);
    wait_status(STAT_RX_VALID, 1'b1, "rx_valid");
    read_expect(ADDR_RXDATA, 32'h3C, "rxdata");
    read_expect(ADDR_STATUS, 32'h0, "status");
  endtask

  task automatic test_error_responses();
    uart_byte_t got;
    logic       sb;
    logic       pb;
    logic       err;
    apb_data_t  rd;
    apb_write(ADDR_TXDATA, 32'h5A, err);
    check_bit("pslverr", err, 1'b0);
    fork
      capture_tx_frame(got, sb, pb);
      begin
        apb_write(ADDR_TXDATA, 32'h11, err);
        check_bit("pslverr busy write", err, 1'b1);
      end
    join
    // frame in flight is untouched by the refused write
    check_bit("start bit", sb, 1'b0);
    check_byte("tx data", got, 8'h5A);
    check_bit("stop bit", pb, 1'b1);
    wait_status(STAT_TX_BUSY, 1'b0, "tx busy to clear");
    apb_read(ADDR_RXDATA, rd, err);
    check_bit("pslverr empty read", err, 1'b1);
    check_data("prdata", rd, 32'h0);
    apb_read(ADDR_TXDATA, rd, err);
    check_bit("pslverr txdata read", err, 1'b1);
    apb_write(ADDR_RXDATA, 32'h77, err);
    check_bit("pslverr rxdata write", err, 1'b1);
    apb_write(12'h00C, 32'hF, err);
    check_bit("pslverr unmapped write", err, 1'b1);
    apb_read(12'h00C, rd, err);
    check_bit("pslverr unmapped read", err, 1'b1);
    read_expect(ADDR_STATUS, 32'h0, "status");
  endtask

  task automatic test_sticky_flags();
    logic err;
    send_serial_frame(8'h11, 1'b1);
    send_serial_frame(8'h22, 1'b1);
    wait_status(STAT_RX_OVERRUN, 1'b1, "overrun");
    read_expect(ADDR_STATUS, 32'h6, "status");
    read_expect(ADDR_RXDATA, 32'h22, "rxdata");
    read_expect(ADDR_STATUS, 32'h4, "status");
    send_serial_frame(8'h33, 1'b0);
    wait_status(STAT_RX_VALID, 1'b1, "rx_valid");
    read_expect(ADDR_STATUS, 32'hE, "status");
    read_expect(ADDR_RXDATA, 32'h33, "rxdata");
    apb_write(ADDR_STATUS, 32'hC, err);
    check_bit("pslverr", err, 1'b0);
    read_expect(ADDR_STATUS, 32'h0, "status");
  endtask

  task automatic test_loopback();
    logic [31:0] rnd;
    uart_byte_t  data;
    logic        err;
    loop_en = 1'b1;
    for (int n = 0; n < 20; n++) begin
      rnd  = $random(seed);
      data = rnd[7:0];
      apb_write(ADDR_TXDATA, {24'h0, data}, err);
      check_bit("pslverr", err, 1'b0);
      wait_status(STAT_RX_VALID, 1'b1, "looped back byte");
      read_expect(ADDR_RXDATA, {24'h0, data}, "rxdata");
      wait_status(STAT_TX_BUSY, 1'b0, "tx busy to clear");
    end
    read_expect(ADDR_STATUS, 32'h0, "status");
    loop_en = 1'b0;
  endtask

  initial begin
    clk     = 1'b0;
    reset   = 1'b1;
    apb_req = '0;
    rx_drv  = 1'b1;
    loop_en = 1'b0;
    seed    = 81;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    test_reset_state();
    test_transmit();
    test_receive();
    test_error_responses();
    test_sticky_flags();
    test_loopback();
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- build.f
uart_pkg.sv
uart_tx.sv
uart_rx.sv
uart_apb_regs.sv
uart_top.sv
uart_checker.sv
uart_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the testbench with Verilator, then run it; a $fatal gives a failing exit status
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module uart_tb -f build.f -o uart_sim

./obj_dir/uart_sim
